// File: ibuf_fifo.sv
// ----------------------------------------------------------
// DEPTH counts the output register, DEPTH must be a power of
// two and at least 2; data_out is valid one cycle after push
// ----------------------------------------------------------
`timescale 1ns/1ps

module ibuf_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   valid_in,
    input  instr_pkg::ibuf_entry_t data_in,
    output logic                   ready_in,

    output logic                   valid_out,
    output instr_pkg::ibuf_entry_t data_out,
    input  logic                   ready_out
);

    localparam int ADDR_W = $clog2(DEPTH);

    // at most DEPTH-1 entries sit here, the last one lives in the output register
    instr_pkg::ibuf_entry_t mem [DEPTH];

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W-1:0] mem_count;

    logic push;
    logic pop;
    logic out_load;
    logic mem_empty;
    logic mem_wr;
    logic mem_rd;

    assign push      = valid_in && ready_in;
    assign pop       = valid_out && ready_out;
    assign mem_empty = (mem_count == '0);

    // the output register takes new data when it is empty or being drained
    assign out_load = !valid_out || pop;

    assign mem_rd = out_load && !mem_empty;

    // a push bypasses storage when it can go straight to the output register
    assign mem_wr = push && !(out_load && mem_empty);

    // full only when storage holds DEPTH-1 and the output register is occupied
    assign ready_in = !(valid_out && (mem_count == ADDR_W'(DEPTH - 1)));

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            mem_count <= '0;
            valid_out <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            mem_count <= mem_count + ADDR_W'(mem_wr) - ADDR_W'(mem_rd);
            if (out_load) begin
                valid_out <= !mem_empty || push;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[wr_ptr] <= data_in;
        end
        if (out_load) begin
            if (!mem_empty) begin
                data_out <= mem[rd_ptr];
            end else if (push) begin
                data_out <= data_in;
            end
        end
    end

endmodule

// File: ibuffer_ctrl.sv
// ----------------------------------------------------------
// a warp id at or above NUM_WARPS is never accepted, it
// stalls decode and counts as a stall cycle
// ----------------------------------------------------------
`timescale 1ns/1ps

module ibuffer_ctrl #(
    parameter int NUM_WARPS = 4
) (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 decode_valid,
    input  warp_pkg::wid_t       decode_wid,
    output logic                 decode_ready,

    input  logic [NUM_WARPS-1:0] fifo_ready_in,
    output logic [NUM_WARPS-1:0] fifo_push,

    input  logic [NUM_WARPS-1:0] fifo_valid_out,
    input  logic [NUM_WARPS-1:0] seq_ready_in,
    output logic [NUM_WARPS-1:0] pop,

    output warp_pkg::perf_ctr_t  perf_stalls
);

    logic [NUM_WARPS-1:0] wid_sel;
    logic                 decode_stall;

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_warp
        assign wid_sel[w]   = (decode_wid == warp_pkg::wid_t'(w));
        assign fifo_push[w] = decode_valid && wid_sel[w];

        // a pop goes upstream as a fetch credit for that warp
        assign pop[w] = fifo_valid_out[w] && seq_ready_in[w];
    end

    // the addressed buffer alone decides whether decode may advance
    assign decode_ready = |(wid_sel & fifo_ready_in);

    assign decode_stall = decode_valid && !decode_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            perf_stalls <= '0;
        end else begin
            perf_stalls <= perf_stalls + warp_pkg::PERF_CTR_BITS'(decode_stall);
        end
    end

endmodule

// File: instr_buffer_tb.sv
// ----------------------------------------------------------
// inputs change on the falling edge, outputs are sampled a
// quarter period later; NUM_WARPS 4 and IBUF_DEPTH 4 assumed
// ----------------------------------------------------------
`timescale 1ns/1ps

module instr_buffer_tb;

    localparam int NUM_WARPS      = 4;
    localparam int IBUF_DEPTH     = 4;
    localparam int CLK_PERIOD     = 100;
    localparam int NUM_ROWS       = 24;
    localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS + 200;
    localparam int BURST_STALLS   = 3;

    localparam instr_pkg::ex_type_e ALU = instr_pkg::EX_ALU;
    localparam instr_pkg::ex_type_e MEM = instr_pkg::EX_MEM;
    localparam instr_pkg::ex_type_e SEQ = instr_pkg::EX_SEQ;

    // hold keeps the warp's issue side stalled, lat checks the empty-warp latency
    typedef struct packed {
        logic                hold;
        logic                lat;
        warp_pkg::wid_t      wid;
        instr_pkg::ex_type_e ex_type;
        instr_pkg::op_args_u op_args;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [31:0]         pc;
    } stim_row_t;

    logic                      clk;
    logic                      reset;
    logic                      decode_valid;
    instr_pkg::decoded_instr_t decode_data;
    logic                      decode_ready;
    logic [NUM_WARPS-1:0]      issue_valid;
    instr_pkg::issue_uop_t     issue_data [NUM_WARPS];
    logic [NUM_WARPS-1:0]      issue_ready = '0;
    logic [NUM_WARPS-1:0]      pop;
    warp_pkg::perf_ctr_t       perf_stalls;

    stim_row_t             stim [NUM_ROWS];
    instr_pkg::issue_uop_t exp_q [NUM_WARPS][$];
    logic [NUM_WARPS-1:0]  force_high = '0;
    logic [NUM_WARPS-1:0]  hold_low = '0;
    logic [31:0]           rnd = 32'h348a_c451;
    int                    rows_sent [NUM_WARPS];
    int                    pop_count [NUM_WARPS];
    int                    stall_count;
    int                    burst_stalls;
    int                    cycle_count;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (5)
    ) u_tb_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    instr_buffer_top #(
        .NUM_WARPS  (NUM_WARPS),
        .IBUF_DEPTH (IBUF_DEPTH)
    ) u_instr_buffer_top (
        .clk          (clk),
        .reset        (reset),
        .decode_valid (decode_valid),
        .decode_data  (decode_data),
        .decode_ready (decode_ready),
        .issue_valid  (issue_valid),
        .issue_data   (issue_data),
        .issue_ready  (issue_ready),
        .pop          (pop),
        .perf_stalls  (perf_stalls)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic compare(input logic [127:0] got, input logic [127:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    function automatic stim_row_t make_row(input logic hold, input logic lat, input int wid,
                                           input instr_pkg::ex_type_e ex, input logic [15:0] args,
                                           input int rd, input int rs1, input int rs2,
                                           input logic [31:0] pc);
        stim_row_t r;
        r.hold    = hold;
        r.lat     = lat;
        r.wid     = warp_pkg::wid_t'(wid);
        r.ex_type = ex;
        r.op_args = args;
        r.rd      = 5'(rd);
        r.rs1     = 5'(rs1);
        r.rs2     = 5'(rs2);
        r.pc      = pc;
        return r;
    endfunction

    // seq args read as {count-1, rd stride, spare}
    task automatic load_table();
        stim[0]  = make_row(1'b0, 1'b1, 0, ALU, 16'h0011, 1, 2, 3, 32'h0000_1000);
        stim[1]  = make_row(1'b0, 1'b0, 1, ALU, 16'h0022, 4, 5, 6, 32'h0000_2000);
        stim[2]  = make_row(1'b0, 1'b0, 2, SEQ, 16'h3200, 7, 1, 2, 32'h0000_3000);
        stim[3]  = make_row(1'b0, 1'b0, 3, MEM, 16'h0040, 8, 9, 10, 32'h0000_4000);
        stim[4]  = make_row(1'b0, 1'b0, 0, SEQ, 16'h1500, 30, 3, 4, 32'h0000_1004);
        stim[5]  = make_row(1'b0, 1'b0, 1, ALU, 16'hfff0, 11, 12, 13, 32'h0000_2004);
        // burst to warp 2 while its issue side is stalled
        stim[6]  = make_row(1'b1, 1'b0, 2, ALU, 16'h0101, 14, 15, 16, 32'h0000_3004);
        stim[7]  = make_row(1'b0, 1'b0, 2, MEM, 16'h0202, 17, 18, 19, 32'h0000_3008);
        stim[8]  = make_row(1'b0, 1'b0, 2, SEQ, 16'h2300, 20, 21, 22, 32'h0000_300c);
        stim[9]  = make_row(1'b0, 1'b0, 2, ALU, 16'h0303, 23, 24, 25, 32'h0000_3010);
        stim[10] = make_row(1'b0, 1'b0, 2, ALU, 16'h0404, 26, 27, 28, 32'h0000_3014);
        stim[11] = make_row(1'b0, 1'b0, 2, MEM, 16'h0505, 29, 30, 31, 32'h0000_3018);
        stim[12] = make_row(1'b0, 1'b0, 3, SEQ, 16'h2f00, 20, 1, 1, 32'h0000_4004);
        stim[13] = make_row(1'b0, 1'b0, 0, ALU, 16'h0aa0, 2, 3, 4, 32'h0000_1008);
        stim[14] = make_row(1'b0, 1'b0, 0, SEQ, 16'h4100, 5, 6, 7, 32'h0000_100c);
        stim[15] = make_row(1'b0, 1'b0, 0, MEM, 16'h0bb0, 8, 9, 10, 32'h0000_1010);
        stim[16] = make_row(1'b0, 1'b0, 0, ALU, 16'h0cc0, 11, 12, 13, 32'h0000_1014);
        stim[17] = make_row(1'b0, 1'b0, 0, ALU, 16'h0dd0, 14, 15, 16, 32'h0000_1018);
        stim[18] = make_row(1'b0, 1'b1, 3, ALU, 16'h1234, 17, 18, 19, 32'h0000_4008);
        stim[19] = make_row(1'b0, 1'b0, 1, ALU, 16'h5678, 0, 1, 2, 32'h0000_2008);
        stim[20] = make_row(1'b0, 1'b0, 2, SEQ, 16'h7100, 28, 4, 5, 32'h0000_301c);
        stim[21] = make_row(1'b0, 1'b0, 3, MEM, 16'h9abc, 6, 7, 8, 32'h0000_400c);
        stim[22] = make_row(1'b0, 1'b0, 0, ALU, 16'hdef0, 9, 10, 11, 32'h0000_101c);
        stim[23] = make_row(1'b0, 1'b0, 1, SEQ, 16'h0300, 12, 13, 14, 32'h0000_200c);
    endtask

    function automatic instr_pkg::decoded_instr_t make_instr(input stim_row_t r, input int i);
        instr_pkg::decoded_instr_t d;
        d.uuid    = 16'h0100 + 16'(i);
        d.wid     = r.wid;
        d.tmask   = 4'hf - 4'(i % 4);
        d.pc      = r.pc;
        d.ex_type = r.ex_type;
        d.op_args = r.op_args;
        d.wb      = (i % 3) != 0;
        d.rd      = r.rd;
        d.rs1     = r.rs1;
        d.rs2     = r.rs2;
        return d;
    endfunction

    // a sequenced instruction gives count+1 uops, rd stepping by the stride modulo 32
    task automatic expect_uops(input instr_pkg::decoded_instr_t d);
        instr_pkg::issue_uop_t u;
        int count;
        int stride;
        if (d.ex_type == instr_pkg::EX_SEQ) begin
            count  = int'(d.op_args.seq.cnt_m1) + 1;
            stride = int'(d.op_args.seq.rd_stride);
        end else begin
            count  = 1;
            stride = 0;
        end
        for (int k = 0; k < count; k++) begin
            u.uuid    = d.uuid;
            u.tmask   = d.tmask;
            u.pc      = d.pc;
            u.ex_type = d.ex_type;
            u.op_args = d.op_args;
            u.wb      = d.wb;
            u.rd      = 5'((int'(d.rd) + k * stride) % 32);
            u.rs1     = d.rs1;
            u.rs2     = d.rs2;
            u.uop_idx = 4'(k);
            u.last    = (k == count - 1);
            exp_q[int'(d.wid)].push_back(u);
        end
    endtask

    function automatic int pending_uops();
        int total;
        total = 0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            total += exp_q[w].size();
        end
        return total;
    endfunction

    task automatic send_row(input int i);
        stim_row_t r;
        int        wi;
        logic      accepted;
        r        = stim[i];
        wi       = int'(r.wid);
        accepted = 1'b0;
        if (r.lat) begin
            // let the warp drain completely before the latency check
            @(negedge clk);
            decode_valid = 1'b0;
            do @(posedge clk); while (exp_q[wi].size() != 0);
            force_high[wi] = 1'b1;
        end else if (r.hold) begin
            @(posedge clk);
            hold_low[wi] = 1'b1;
        end
        @(negedge clk);
        decode_valid = 1'b1;
        decode_data  = make_instr(r, i);
        while (!accepted) begin
            #(CLK_PERIOD / 4);
            if (decode_ready) begin
                accepted = 1'b1;
            end else begin
                stall_count++;
                if (hold_low[wi]) begin
                    burst_stalls++;
                    if (burst_stalls >= BURST_STALLS) begin
                        hold_low[wi] = 1'b0;
                    end
                end
                @(negedge clk);
            end
        end
        expect_uops(decode_data);
        rows_sent[wi]++;
        if (r.lat) begin
            compare(128'(issue_valid[wi]), '0, "issue_valid in the accepting cycle");
            @(negedge clk);
            decode_valid = 1'b0;
            #(CLK_PERIOD / 4);
            compare(128'(issue_valid[wi]), 128'(1), "issue_valid one cycle after acceptance");
            force_high[wi] = 1'b0;
        end
    endtask

    // issue-side stall model and run limit, one step per falling edge
    always @(negedge clk) begin
        rnd = lcg_next(rnd);
        cycle_count++;
        for (int w = 0; w < NUM_WARPS; w++) begin
            issue_ready[w] = force_high[w] | (!hold_low[w] & (rnd[20 + 2 * w] | rnd[21 + 2 * w]));
        end
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // every issued uop must match the head of its warp's queue
    always begin
        instr_pkg::issue_uop_t exp_uop;
        @(negedge clk);
        #(CLK_PERIOD / 4);
        if (!reset) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                if (pop[w]) begin
                    pop_count[w]++;
                end
                if (issue_valid[w] && issue_ready[w]) begin
                    if (exp_q[w].size() == 0) begin
                        $display("warp %0d issued a uop that was never expected at %0t ns",
                                 w, $time);
                        abort_run();
                    end else begin
                        exp_uop = exp_q[w].pop_front();
                        compare(128'(issue_data[w]), 128'(exp_uop),
                                $sformatf("uop on warp %0d", w));
                    end
                end
            end
        end
    end

    initial begin
        decode_valid = 1'b0;
        decode_data  = '0;
        load_table();
        @(negedge reset);
        @(negedge clk);
        #(CLK_PERIOD / 4);
        compare(128'(issue_valid), '0, "issue_valid after reset");
        compare(128'(pop), '0, "pop after reset");
        compare(128'(perf_stalls), '0, "perf_stalls after reset");
        for (int i = 0; i < NUM_ROWS; i++) begin
            send_row(i);
        end
        @(negedge clk);
        decode_valid = 1'b0;
        compare(128'(burst_stalls), 128'(BURST_STALLS), "decode stall cycles during the burst");
        while (pending_uops() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        #(CLK_PERIOD / 4);
        for (int w = 0; w < NUM_WARPS; w++) begin
            compare(128'(pop_count[w]), 128'(rows_sent[w]), $sformatf("pop count of warp %0d", w));
        end
        compare(128'(perf_stalls), 128'(stall_count), "perf_stalls at the end");
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: instr_buffer_top.sv
// ----------------------------------------------------------
// NUM_WARPS from 1 to 8, IBUF_DEPTH a power of two >= 2
// ----------------------------------------------------------
`timescale 1ns/1ps

module instr_buffer_top #(
    parameter int NUM_WARPS  = 4,
    parameter int IBUF_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       decode_valid,
    input  instr_pkg::decoded_instr_t  decode_data,
    output logic                       decode_ready,

    output logic [NUM_WARPS-1:0]       issue_valid,
    output instr_pkg::issue_uop_t      issue_data [NUM_WARPS],
    input  logic [NUM_WARPS-1:0]       issue_ready,

    output logic [NUM_WARPS-1:0]       pop,
    output warp_pkg::perf_ctr_t        perf_stalls
);

    instr_pkg::ibuf_entry_t decode_entry;
    instr_pkg::ibuf_entry_t fifo_data [NUM_WARPS];

    logic [NUM_WARPS-1:0] fifo_push;
    logic [NUM_WARPS-1:0] fifo_ready_in;
    logic [NUM_WARPS-1:0] fifo_valid_out;
    logic [NUM_WARPS-1:0] seq_ready_in;

    // the warp id is dropped, each buffer holds one warp only
    assign decode_entry = '{
        uuid:    decode_data.uuid,
        tmask:   decode_data.tmask,
        pc:      decode_data.pc,
        ex_type: decode_data.ex_type,
        op_args: decode_data.op_args,
        wb:      decode_data.wb,
        rd:      decode_data.rd,
        rs1:     decode_data.rs1,
        rs2:     decode_data.rs2
    };

    ibuffer_ctrl #(
        .NUM_WARPS (NUM_WARPS)
    ) u_ibuffer_ctrl (
        .clk            (clk),
        .reset          (reset),
        .decode_valid   (decode_valid),
        .decode_wid     (decode_data.wid),
        .decode_ready   (decode_ready),
        .fifo_ready_in  (fifo_ready_in),
        .fifo_push      (fifo_push),
        .fifo_valid_out (fifo_valid_out),
        .seq_ready_in   (seq_ready_in),
        .pop            (pop),
        .perf_stalls    (perf_stalls)
    );

    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_warp
        ibuf_fifo #(
            .DEPTH (IBUF_DEPTH)
        ) u_ibuf_fifo (
            .clk       (clk),
            .reset     (reset),
            .valid_in  (fifo_push[w]),
            .data_in   (decode_entry),
            .ready_in  (fifo_ready_in[w]),
            .valid_out (fifo_valid_out[w]),
            .data_out  (fifo_data[w]),
            .ready_out (seq_ready_in[w])
        );

        uop_sequencer u_uop_sequencer (
            .clk         (clk),
            .reset       (reset),
            .valid_in    (fifo_valid_out[w]),
            .data_in     (fifo_data[w]),
            .ready_in    (seq_ready_in[w]),
            .issue_valid (issue_valid[w]),
            .issue_data  (issue_data[w]),
            .issue_ready (issue_ready[w])
        );
    end

endmodule

// File: instr_pkg.sv
// ----------------------------------------------------------
// decoded instruction and issued uop formats
// op_args is read through its seq view only for EX_SEQ
// ----------------------------------------------------------
package instr_pkg;

    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_MEM = 2'd1,
        EX_SEQ = 2'd2
    } ex_type_e;

    // plain immediate used by ALU and memory instructions
    typedef struct packed {
        logic [15:0] imm;
    } alu_args_t;

    // a sequenced instruction expands into cnt_m1+1 uops, rd stepping by rd_stride
    typedef struct packed {
        logic [3:0] cnt_m1;
        logic [3:0] rd_stride;
        logic [7:0] spare;
    } seq_args_t;

    typedef union packed {
        alu_args_t alu;
        seq_args_t seq;
    } op_args_u;

    typedef struct packed {
        logic [15:0]     uuid;
        warp_pkg::wid_t  wid;
        logic [3:0]      tmask;
        logic [31:0]     pc;
        ex_type_e        ex_type;
        op_args_u        op_args;
        logic            wb;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
    } decoded_instr_t;

    // one buffer slot, the warp is implied by which buffer holds it
    typedef struct packed {
        logic [15:0] uuid;
        logic [3:0]  tmask;
        logic [31:0] pc;
        ex_type_e    ex_type;
        op_args_u    op_args;
        logic        wb;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
    } ibuf_entry_t;

    typedef struct packed {
        logic [15:0] uuid;
        logic [3:0]  tmask;
        logic [31:0] pc;
        ex_type_e    ex_type;
        op_args_u    op_args;
        logic        wb;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [3:0]  uop_idx;
        logic        last;
    } issue_uop_t;

endpackage

// File: list.f
warp_pkg.sv
instr_pkg.sv
ibuf_fifo.sv
uop_sequencer.sv
ibuffer_ctrl.sv
instr_buffer_top.sv
tb_clock_gen.sv
instr_buffer_tb.sv

// File: run.sh
#!/bin/sh
# builds the instruction buffer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f list.f --top-module instr_buffer_tb -o sim_instr_buffer

# the simulator exits non-zero on a fatal error, the log decides the result
./obj_dir/sim_instr_buffer > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

// File: tb_clock_gen.sv
// ----------------------------------------------------------
// free-running clock, reset held high for RESET_CYCLES rising
// edges and released on a falling edge
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        // release away from the rising edge so the DUT sees a clean first cycle
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// File: uop_sequencer.sv
// ----------------------------------------------------------
// no added latency, the input entry is held until its last
// uop issues; rd steps wrap modulo 32
// ----------------------------------------------------------
`timescale 1ns/1ps

module uop_sequencer (
    input  logic                   clk,
    input  logic                   reset,

    input  logic                   valid_in,
    input  instr_pkg::ibuf_entry_t data_in,
    output logic                   ready_in,

    output logic                   issue_valid,
    output instr_pkg::issue_uop_t  issue_data,
    input  logic                   issue_ready
);

    logic [3:0] uop_idx;
    logic       is_seq;
    logic [3:0] uop_cnt_m1;
    logic [3:0] rd_stride;
    logic [7:0] rd_offset;
    logic       last_uop;
    logic       issue_fire;

    always_comb begin
        is_seq = (data_in.ex_type == instr_pkg::EX_SEQ);

        // other types read op_args as an immediate, so they expand to a single uop
        uop_cnt_m1 = is_seq ? data_in.op_args.seq.cnt_m1 : 4'd0;
        rd_stride  = is_seq ? data_in.op_args.seq.rd_stride : 4'd0;

        rd_offset = uop_idx * rd_stride;
        last_uop  = (uop_idx == uop_cnt_m1);
    end

    assign issue_valid = valid_in;
    assign issue_fire  = valid_in && issue_ready;

    // the buffer entry is consumed together with the final uop
    assign ready_in = issue_ready && last_uop;

    always_comb begin
        issue_data.uuid    = data_in.uuid;
        issue_data.tmask   = data_in.tmask;
        issue_data.pc      = data_in.pc;
        issue_data.ex_type = data_in.ex_type;
        issue_data.op_args = data_in.op_args;
        issue_data.wb      = data_in.wb;
        issue_data.rd      = data_in.rd + rd_offset[4:0];
        issue_data.rs1     = data_in.rs1;
        issue_data.rs2     = data_in.rs2;
        issue_data.uop_idx = uop_idx;
        issue_data.last    = last_uop;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            uop_idx <= '0;
        end else if (issue_fire) begin
            if (last_uop) begin
                uop_idx <= '0;
            end else begin
                uop_idx <= uop_idx + 4'd1;
            end
        end
    end

endmodule

// File: warp_pkg.sv
// ----------------------------------------------------------
// warp-level types shared by the instruction buffer stage
// at most MAX_WARPS warps, the top level may use fewer
// ----------------------------------------------------------
package warp_pkg;

    // upper bound on warps per core, the width of a warp id follows from it
    localparam int MAX_WARPS = 8;
    localparam int WID_BITS = $clog2(MAX_WARPS);

    // width of the performance counters, wraps silently on overflow
    localparam int PERF_CTR_BITS = 32;

    typedef logic [WID_BITS-1:0] wid_t;

    typedef logic [PERF_CTR_BITS-1:0] perf_ctr_t;

endpackage
